// File: source/eth_switch_pkg.sv
//////////////////////////////////////////////////
// shared widths, protocol constants and types
// header offsets assume an untagged frame with a
// 20-byte IPv4 header; anything else routes to ps
//////////////////////////////////////////////////
`default_nettype none

package eth_switch_pkg;

    // basic widths
    typedef logic [7:0] byte_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] pkt_count_t;
    // byte position, saturates at its top value
    typedef logic [5:0] hdr_offset_t;

    localparam int NUM_UDP_PORTS = 8;
    localparam int FRAME_FIFO_DEPTH = 1024;
    localparam int ROUTE_FIFO_DEPTH = 4;

    typedef udp_port_t [NUM_UDP_PORTS-1:0] port_table_t;

    // frame buffer item
    typedef struct packed {
        byte_t data;
        logic  last;
    } stream_beat_t;

    // route queue item
    typedef enum logic {
        ROUTE_PS = 1'b0,
        ROUTE_CS = 1'b1
    } route_t;

    // protocol constants
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam byte_t IPV4_VER_IHL = 8'h45;
    localparam byte_t IP_PROTO_UDP = 8'h11;

    // byte offsets from start of frame
    localparam hdr_offset_t OFF_ETHERTYPE = 6'd12;
    localparam hdr_offset_t OFF_VER_IHL = 6'd14;
    localparam hdr_offset_t OFF_IP_PROTO = 6'd23;
    localparam hdr_offset_t OFF_UDP_DPORT = 6'd36;
    // shortest frame that still holds the whole dest port
    localparam hdr_offset_t MIN_CS_LEN = 6'd38;

endpackage

`default_nettype wire

// File: source/byte_stream_if.sv
//////////////////////////////////////////////////
// valid/ready byte stream with end-of-frame flag
// source holds data and last while ready is low
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

interface byte_stream_if;
    import eth_switch_pkg::*;

    byte_t data;
    logic  valid;
    logic  ready;
    // marks final byte of a frame
    logic  last;

    modport source (
        output data,
        output valid,
        output last,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

// File: source/sync_fifo.sv
//////////////////////////////////////////////////
// single-clock queue, registered write and a
// read port that shows the head combinationally
// depth must be at least 2
// push while full and pop while empty are illegal
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter type item_t = logic,
    parameter int  depth = 4
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  push,
    input  item_t push_item,
    output logic  full,
    input  logic  pop,
    output item_t pop_item,
    output logic  empty
);

    localparam int addr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    item_t mem [depth];
    logic [addr_w-1:0] wr_ptr;
    logic [addr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    // storage, no reset needed
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    // pointers wrap at depth, not at a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == addr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == addr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy moves only when one side is active
            if (push && !pop) begin
                count <= count + cnt_w'(1);
            end else if (pop && !push) begin
                count <= count - cnt_w'(1);
            end
        end
    end

    assign full = (count == cnt_w'(depth));
    assign empty = (count == '0);
    // head item, valid whenever not empty
    assign pop_item = mem[rd_ptr];

    // neighbours must respect the flags
    a_no_overflow : assert property (@(posedge clk) disable iff (reset)
        full |-> !push);
    a_no_underflow : assert property (@(posedge clk) disable iff (reset)
        empty |-> !pop);

endmodule

`default_nettype wire

// File: source/rx_frame_classifier.sv
//////////////////////////////////////////////////
// passes input bytes into the frame buffer and
// picks one route per frame at its last byte
// frames longer than FRAME_FIFO_DEPTH stall forever
// udp_ports must hold still while frames are queued
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module rx_frame_classifier (
    input  logic                         clk,
    input  logic                         reset,
    byte_stream_if.sink                  s_in,
    input  eth_switch_pkg::port_table_t  udp_ports,
    output logic                         beat_push,
    output eth_switch_pkg::stream_beat_t beat_item,
    input  logic                         beat_full,
    output logic                         route_push,
    output eth_switch_pkg::route_t       route_item,
    input  logic                         route_full
);
    import eth_switch_pkg::*;

    hdr_offset_t pos;
    logic [15:0] eth_type;
    byte_t ver_ihl;
    byte_t ip_proto;
    byte_t dport_hi;
    byte_t dport_lo;
    udp_port_t dport;
    logic port_hit;
    logic len_ok;

    // last byte also needs room in the route queue
    assign s_in.ready = !beat_full && (!s_in.last || !route_full);
    assign beat_push = s_in.valid && s_in.ready;
    assign beat_item = '{data: s_in.data, last: s_in.last};
    assign route_push = beat_push && s_in.last;

    // byte position within the frame
    always_ff @(posedge clk) begin
        if (reset) begin
            pos <= '0;
        end else if (beat_push) begin
            if (s_in.last) begin
                pos <= '0;
            end else if (pos != '1) begin
                pos <= pos + 1'b1;
            end
        end
    end

    // grab header fields as they go by
    always_ff @(posedge clk) begin
        if (beat_push) begin
            case (pos)
                OFF_ETHERTYPE:              eth_type[15:8] <= s_in.data;
                OFF_ETHERTYPE + 6'd1:       eth_type[7:0] <= s_in.data;
                OFF_VER_IHL:                ver_ihl <= s_in.data;
                OFF_IP_PROTO:               ip_proto <= s_in.data;
                OFF_UDP_DPORT:              dport_hi <= s_in.data;
                OFF_UDP_DPORT + 6'd1:       dport_lo <= s_in.data;
                default: ;
            endcase
        end
    end

    // low port byte may be the current one when the frame ends there
    assign dport = (pos == OFF_UDP_DPORT + 6'd1) ? {dport_hi, s_in.data}
                                                 : {dport_hi, dport_lo};
    // last byte at position 37 or later means every field was seen
    assign len_ok = (pos >= MIN_CS_LEN - 6'd1);

    // compare against all configured ports
    always_comb begin
        port_hit = 1'b0;
        for (int i = 0; i < NUM_UDP_PORTS; i++) begin
            if (udp_ports[i] == dport) begin
                port_hit = 1'b1;
            end
        end
    end

    assign route_item = (len_ok && eth_type == ETHERTYPE_IPV4 && ver_ihl == IPV4_VER_IHL &&
                         ip_proto == IP_PROTO_UDP && port_hit) ? ROUTE_CS : ROUTE_PS;

    // a refused input byte stays offered and unchanged
    a_input_hold : assert property (@(posedge clk) disable iff (reset)
        s_in.valid && !s_in.ready |=>
            s_in.valid && $stable(s_in.data) && $stable(s_in.last));

endmodule

`default_nettype wire

// File: source/tx_route_switch.sv
//////////////////////////////////////////////////
// drains the frame buffer one frame at a time to
// the output named by the head route
// a stalled output blocks the other one too
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tx_route_switch (
    input  logic                         clk,
    input  logic                         reset,
    output logic                         beat_pop,
    input  eth_switch_pkg::stream_beat_t beat_item,
    input  logic                         beat_empty,
    output logic                         route_pop,
    input  eth_switch_pkg::route_t       route_item,
    input  logic                         route_empty,
    byte_stream_if.source                cs_out,
    byte_stream_if.source                ps_out,
    output eth_switch_pkg::pkt_count_t   cs_pkt_count,
    output eth_switch_pkg::pkt_count_t   ps_pkt_count
);
    import eth_switch_pkg::*;

    typedef enum logic {
        SW_IDLE,
        SW_SEND
    } sw_state_t;

    sw_state_t state;
    route_t cur_route;
    logic head_ok;
    logic sel_ready;
    logic frame_done;

    // take the next route only between frames
    assign route_pop = (state == SW_IDLE) && !route_empty;

    // head beat present while sending
    assign head_ok = (state == SW_SEND) && !beat_empty;

    assign cs_out.valid = head_ok && (cur_route == ROUTE_CS);
    assign ps_out.valid = head_ok && (cur_route == ROUTE_PS);
    // valid alone marks which output owns the byte
    assign cs_out.data = beat_item.data;
    assign cs_out.last = beat_item.last;
    assign ps_out.data = beat_item.data;
    assign ps_out.last = beat_item.last;

    assign sel_ready = (cur_route == ROUTE_CS) ? cs_out.ready : ps_out.ready;
    assign beat_pop = head_ok && sel_ready;
    assign frame_done = beat_pop && beat_item.last;

    // FSM waits in idle until a route is queued
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SW_IDLE;
            cur_route <= ROUTE_PS;
        end else begin
            case (state)
                SW_IDLE: begin
                    if (route_pop) begin
                        cur_route <= route_item;
                        state <= SW_SEND;
                    end
                end
                SW_SEND: begin
                    if (frame_done) begin
                        state <= SW_IDLE;
                    end
                end
                default: state <= SW_IDLE;
            endcase
        end
    end

    // frame counters wrap at 16 bits
    always_ff @(posedge clk) begin
        if (reset) begin
            cs_pkt_count <= '0;
            ps_pkt_count <= '0;
        end else if (frame_done) begin
            if (cur_route == ROUTE_CS) begin
                cs_pkt_count <= cs_pkt_count + 1'b1;
            end else begin
                ps_pkt_count <= ps_pkt_count + 1'b1;
            end
        end
    end

    // a queued route always has its frame's bytes behind it
    a_route_has_frame : assert property (@(posedge clk) disable iff (reset)
        route_pop |-> !beat_empty);

    // a waiting cs byte stays offered and unchanged
    a_cs_hold : assert property (@(posedge clk) disable iff (reset)
        cs_out.valid && !cs_out.ready |=> cs_out.valid && $stable(cs_out.data));

endmodule

`default_nettype wire

// File: source/eth_rx_switch.sv
//////////////////////////////////////////////////
// ethernet receive switch, frames leave whole on
// cs (matched UDP/IPv4) or ps (everything else)
// frames keep arrival order across both outputs
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module eth_rx_switch (
    input  logic                        clk,
    input  logic                        reset,
    input  eth_switch_pkg::byte_t       s_data,
    input  logic                        s_valid,
    output logic                        s_ready,
    input  logic                        s_last,
    input  eth_switch_pkg::port_table_t udp_ports,
    output eth_switch_pkg::byte_t       cs_data,
    output logic                        cs_valid,
    input  logic                        cs_ready,
    output logic                        cs_last,
    output eth_switch_pkg::byte_t       ps_data,
    output logic                        ps_valid,
    input  logic                        ps_ready,
    output logic                        ps_last,
    output eth_switch_pkg::pkt_count_t  cs_pkt_count,
    output eth_switch_pkg::pkt_count_t  ps_pkt_count
);
    import eth_switch_pkg::*;

    byte_stream_if s_if ();
    byte_stream_if cs_if ();
    byte_stream_if ps_if ();

    logic beat_push;
    logic beat_full;
    logic beat_pop;
    logic beat_empty;
    stream_beat_t beat_in;
    stream_beat_t beat_out;
    logic route_push;
    logic route_full;
    logic route_pop;
    logic route_empty;
    route_t route_in;
    route_t route_out;

    // input port onto the internal stream
    assign s_if.data = s_data;
    assign s_if.valid = s_valid;
    assign s_if.last = s_last;
    assign s_ready = s_if.ready;

    // output streams back to plain ports
    assign cs_data = cs_if.data;
    assign cs_valid = cs_if.valid;
    assign cs_last = cs_if.last;
    assign cs_if.ready = cs_ready;
    assign ps_data = ps_if.data;
    assign ps_valid = ps_if.valid;
    assign ps_last = ps_if.last;
    assign ps_if.ready = ps_ready;

    rx_frame_classifier classifier (
        .clk(clk), .reset(reset), .s_in(s_if), .udp_ports(udp_ports),
        .beat_push(beat_push), .beat_item(beat_in), .beat_full(beat_full),
        .route_push(route_push), .route_item(route_in), .route_full(route_full)
    );

    // holds bytes until the route is known
    sync_fifo #(.item_t(stream_beat_t), .depth(FRAME_FIFO_DEPTH)) frame_fifo (
        .clk(clk), .reset(reset), .push(beat_push), .push_item(beat_in), .full(beat_full),
        .pop(beat_pop), .pop_item(beat_out), .empty(beat_empty)
    );

    // one decision per frame in flight
    sync_fifo #(.item_t(route_t), .depth(ROUTE_FIFO_DEPTH)) route_fifo (
        .clk(clk), .reset(reset), .push(route_push), .push_item(route_in), .full(route_full),
        .pop(route_pop), .pop_item(route_out), .empty(route_empty)
    );

    tx_route_switch switcher (
        .clk(clk), .reset(reset),
        .beat_pop(beat_pop), .beat_item(beat_out), .beat_empty(beat_empty),
        .route_pop(route_pop), .route_item(route_out), .route_empty(route_empty),
        .cs_out(cs_if), .ps_out(ps_if),
        .cs_pkt_count(cs_pkt_count), .ps_pkt_count(ps_pkt_count)
    );

endmodule

`default_nettype wire

// File: tb/frame_table.svh
//////////////////////////////////////////////////
// test frames, one row per frame, plus the port
// table loaded into the DUT
// included inside the testbench module body
//////////////////////////////////////////////////
`ifndef FRAME_TABLE_SVH
`define FRAME_TABLE_SVH

typedef struct packed {
    int        len;
    udp_port_t eth_type;
    byte_t     ver_ihl;
    byte_t     proto;
    udp_port_t dport;
    route_t    route;
    logic      bp;
} frame_row_t;

localparam int NUM_FRAMES = 15;

localparam udp_port_t UDP_PORT_LIST [NUM_UDP_PORTS] = '{
    16'd53, 16'd67, 16'd123, 16'd161, 16'd514, 16'd4789, 16'd5000, 16'd65534
};

// len, ethertype, ver/ihl, proto, dport, expected route, random ready
localparam frame_row_t FRAME_TABLE [NUM_FRAMES] = '{
    '{64,  16'h0800, 8'h45, 8'h11, 16'd53,    ROUTE_CS, 1'b0},
    '{60,  16'h0800, 8'h45, 8'h11, 16'd4789,  ROUTE_CS, 1'b0},
    '{90,  16'h0800, 8'h45, 8'h11, 16'd65534, ROUTE_CS, 1'b0},
    '{60,  16'h86dd, 8'h45, 8'h11, 16'd53,    ROUTE_PS, 1'b0},
    '{60,  16'h0800, 8'h46, 8'h11, 16'd53,    ROUTE_PS, 1'b0},
    '{60,  16'h0800, 8'h45, 8'h06, 16'd53,    ROUTE_PS, 1'b0},
    '{60,  16'h0800, 8'h45, 8'h11, 16'd54,    ROUTE_PS, 1'b0},
    '{37,  16'h0800, 8'h45, 8'h11, 16'd53,    ROUTE_PS, 1'b0},
    '{1,   16'h0800, 8'h45, 8'h11, 16'd53,    ROUTE_PS, 1'b0},
    '{38,  16'h0800, 8'h45, 8'h11, 16'd161,   ROUTE_CS, 1'b0},
    '{120, 16'h0800, 8'h45, 8'h11, 16'd5000,  ROUTE_CS, 1'b1},
    '{70,  16'h0800, 8'h45, 8'h11, 16'd67,    ROUTE_CS, 1'b1},
    '{50,  16'h0806, 8'h45, 8'h11, 16'd67,    ROUTE_PS, 1'b1},
    '{200, 16'h0800, 8'h45, 8'h11, 16'd514,   ROUTE_CS, 1'b1},
    '{45,  16'h0800, 8'h45, 8'h11, 16'd123,   ROUTE_CS, 1'b1}
};

`endif

// File: tb/eth_rx_switch_tb.sv
//////////////////////////////////////////////////
// drives the frame table through the switch and
// checks each output byte against per-route queues
// random ready only on rows flagged for it
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module eth_rx_switch_tb;
    import eth_switch_pkg::*;
    `include "frame_table.svh"

    logic clk;
    logic reset;
    byte_t s_data;
    logic s_valid;
    logic s_ready;
    logic s_last;
    port_table_t udp_ports;
    byte_t cs_data;
    logic cs_valid;
    logic cs_ready;
    logic cs_last;
    byte_t ps_data;
    logic ps_valid;
    logic ps_ready;
    logic ps_last;
    pkt_count_t cs_pkt_count;
    pkt_count_t ps_pkt_count;

    // expected beats as {last, data}
    logic [8:0] cs_exp [$];
    logic [8:0] ps_exp [$];
    int seed = 69;
    int errors = 0;
    int checked = 0;
    int cycles = 0;
    int cycle_limit;
    int cs_frames;
    int ps_frames;

    eth_rx_switch uut (
        .clk(clk), .reset(reset),
        .s_data(s_data), .s_valid(s_valid), .s_ready(s_ready), .s_last(s_last),
        .udp_ports(udp_ports),
        .cs_data(cs_data), .cs_valid(cs_valid), .cs_ready(cs_ready), .cs_last(cs_last),
        .ps_data(ps_data), .ps_valid(ps_valid), .ps_ready(ps_ready), .ps_last(ps_last),
        .cs_pkt_count(cs_pkt_count), .ps_pkt_count(ps_pkt_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // classification rule applied to a table row
    function automatic route_t rule_route(input frame_row_t row);
        logic port_hit;
        port_hit = 1'b0;
        for (int i = 0; i < NUM_UDP_PORTS; i++) begin
            if (UDP_PORT_LIST[i] == row.dport) begin
                port_hit = 1'b1;
            end
        end
        if (row.len >= 38 && row.eth_type == 16'h0800 && row.ver_ihl == 8'h45 &&
            row.proto == 8'h11 && port_hit) begin
            return ROUTE_CS;
        end
        return ROUTE_PS;
    endfunction

    // header fields at fixed offsets and fill bytes elsewhere
    function automatic byte_t frame_byte(input frame_row_t row, input int k, input byte_t fill);
        case (k)
            12: return row.eth_type[15:8];
            13: return row.eth_type[7:0];
            14: return row.ver_ihl;
            23: return row.proto;
            36: return row.dport[15:8];
            37: return row.dport[7:0];
            default: return fill;
        endcase
    endfunction

    function automatic int total_table_bytes();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            sum += FRAME_TABLE[i].len;
        end
        return sum;
    endfunction

    task automatic expect_idle(input string phase);
        if (cs_valid !== 1'b0 || ps_valid !== 1'b0) begin
            errors++;
            $display("mismatch at %0t: output valid high %s", $time, phase);
        end
        if (cs_pkt_count !== '0 || ps_pkt_count !== '0) begin
            errors++;
            $display("mismatch at %0t: frame counters not zero %s", $time, phase);
        end
    endtask

    // one output handshake against the head of its queue
    task automatic compare_output(input route_t route, input byte_t data, input logic last);
        logic [8:0] want;
        int left;
        string name;
        name = (route == ROUTE_CS) ? "cs" : "ps";
        left = (route == ROUTE_CS) ? cs_exp.size() : ps_exp.size();
        if (left == 0) begin
            errors++;
            $display("unexpected byte %h on %s output at %0t", data, name, $time);
            return;
        end
        want = (route == ROUTE_CS) ? cs_exp.pop_front() : ps_exp.pop_front();
        checked++;
        if (want != {last, data}) begin
            errors++;
            $display("mismatch at %0t: %s got data %h last %b, expected data %h last %b",
                     $time, name, data, last, want[7:0], want[8]);
        end
    endtask

    // drives one frame and randomises output ready on bp rows
    task automatic drive_frame(input frame_row_t row);
        int rnd;
        byte_t b;
        logic [8:0] beat;
        for (int k = 0; k < row.len; k++) begin
            rnd = $random(seed);
            b = frame_byte(row, k, rnd[7:0]);
            beat = {k == row.len - 1, b};
            s_data <= b;
            s_valid <= 1'b1;
            s_last <= beat[8];
            if (row.route == ROUTE_CS) begin
                cs_exp.push_back(beat);
            end else begin
                ps_exp.push_back(beat);
            end
            do begin
                @(posedge clk);
                rnd = $random(seed);
                cs_ready <= row.bp ? rnd[0] : 1'b1;
                ps_ready <= row.bp ? rnd[1] : 1'b1;
            end while (!s_ready);
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (cs_valid && cs_ready) begin
                compare_output(ROUTE_CS, cs_data, cs_last);
            end
            if (ps_valid && ps_ready) begin
                compare_output(ROUTE_PS, ps_data, ps_last);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d cs and %0d ps bytes never arrived",
                     cycles, cs_exp.size(), ps_exp.size());
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        cycle_limit = total_table_bytes() * 8 + 200;
        reset = 1'b1;
        s_data = '0;
        s_valid = 1'b0;
        s_last = 1'b0;
        cs_ready = 1'b1;
        ps_ready = 1'b1;
        for (int i = 0; i < NUM_UDP_PORTS; i++) begin
            udp_ports[i] = UDP_PORT_LIST[i];
        end
        cs_frames = 0;
        ps_frames = 0;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            if (rule_route(FRAME_TABLE[i]) != FRAME_TABLE[i].route) begin
                errors++;
                $display("frame table row %0d route disagrees with the classification rule", i);
            end
            if (FRAME_TABLE[i].route == ROUTE_CS) begin
                cs_frames++;
            end else begin
                ps_frames++;
            end
        end

        // reset stays high for four rising edges
        repeat (3) @(posedge clk);
        @(negedge clk);
        expect_idle("during reset");
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        expect_idle("after reset");

        @(posedge clk);
        for (int i = 0; i < NUM_FRAMES; i++) begin
            drive_frame(FRAME_TABLE[i]);
        end
        s_valid <= 1'b0;
        s_last <= 1'b0;
        cs_ready <= 1'b1;
        ps_ready <= 1'b1;

        // wait for the drain and leave time for stray bytes
        while (cs_exp.size() != 0 || ps_exp.size() != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        if (cs_pkt_count != pkt_count_t'(cs_frames)) begin
            errors++;
            $display("mismatch at %0t: cs_pkt_count %0d, expected %0d",
                     $time, cs_pkt_count, cs_frames);
        end
        if (ps_pkt_count != pkt_count_t'(ps_frames)) begin
            errors++;
            $display("mismatch at %0t: ps_pkt_count %0d, expected %0d",
                     $time, ps_pkt_count, ps_frames);
        end

        $display("%0d bytes checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+tb
source/eth_switch_pkg.sv
source/byte_stream_if.sv
source/sync_fifo.sv
source/rx_frame_classifier.sv
source/tx_route_switch.sv
source/eth_rx_switch.sv
tb/eth_rx_switch_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module eth_rx_switch_tb -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
